// ==== Bender.yml ====
package:
  name: tiny_fabric

sources:
  - hw/fabric_cfg_pkg.sv
  - hw/fabric_io_pkg.sv
  - hw/cfg_chain_if.sv
  - hw/pin_ingress.sv
  - hw/logic_tile.sv
  - hw/pin_egress.sv
  - hw/fabric_top.sv
  - target: test
    files:
      - bench/fabric_checker.sv
      - bench/fabric_tb.sv

// ==== bench/fabric_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_checker
  import fabric_io_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     cen,
  input logic     cset,
  input logic     cset_out,
  input logic     shift_out,
  input pin_bus_t pin_out
);

  // Count of failed assertions
  int fail_count = 0;

  // Reset edge clears the pin register
  a_reset_pins: assert property (@(posedge clk) !rst_n |=> pin_out == '0)
    else begin
      fail_count++;
      $error("pin_out not cleared while rst_n low");
    end

  // cset travels the row unchanged
  a_cset_echo: assert property (@(posedge clk) cset_out == cset)
    else begin
      fail_count++;
      $error("cset_out differs from cset");
    end

  // No shift without cen
  a_shift_hold: assert property (@(posedge clk) disable iff (!rst_n) !cen |=> $stable(shift_out))
    else begin
      fail_count++;
      $error("shift_out moved while cen low");
    end

endmodule

`default_nettype wire

// ==== bench/fabric_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_tb
  import fabric_cfg_pkg::*;
  import fabric_io_pkg::*;
();

  localparam int SEED = 67114;
  localparam int WATCHDOG_CYCLES = 6 * CHAIN_LEN + 2000;
  // Selects sit low in each LUT field with the mask above them
  localparam int MASK_POS = LUT_INPUTS * SEL_W;
  // Register bit tops the LUT field
  localparam int REG_POS = LUT_CFG_W - 1;
  // Register bit policy for random configs
  localparam int MODE_COMB = 0;
  localparam int MODE_REG = 1;
  localparam int MODE_MIX = 2;

  typedef logic [CHAIN_LEN-1:0] chain_bits_t;

  logic     clk;
  logic     rst_n;
  logic     en;
  logic     cen;
  logic     cset;
  logic     shift_in;
  pin_bus_t pin_in;
  pin_bus_t pin_out;
  logic     shift_out;
  logic     cset_out;

  // Model config where pending mirrors the shadow chain
  tile_cfg_t   pend_tile [NUM_TILES];
  tile_cfg_t   act_tile [NUM_TILES];
  egress_cfg_t pend_egr;
  egress_cfg_t act_egr;
  // Model data state with one copy per LUT flop
  pin_bus_t    m_pin_q;
  pin_bus_t    m_pin_out;
  pin_bus_t    m_next;
  tap_bus_t    m_lut_q;
  tap_bus_t    m_comb;

  int checks;
  int errors;

  fabric_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .cen       (cen),
    .cset      (cset),
    .shift_in  (shift_in),
    .pin_in    (pin_in),
    .pin_out   (pin_out),
    .shift_out (shift_out),
    .cset_out  (cset_out)
  );

  bind fabric_top fabric_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .cen       (cen),
    .cset      (cset),
    .cset_out  (cset_out),
    .shift_out (shift_out),
    .pin_out   (pin_out)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic check_pins(input string name, input pin_bus_t exp, input pin_bus_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // Expected pins after the next en edge and the new LUT results
  function automatic pin_bus_t ref_pins(input pin_bus_t pin_q, input tap_bus_t lut_q,
                                        output tap_bus_t comb);
    lane_t               west;
    lane_t               east;
    logic [2*LANE_W-1:0] cand;
    logic [LUT_INPUTS-1:0] idx;
    lut_sel_t            sel;
    lut_mask_t           mask;
    tap_bus_t            taps;
    pin_bus_t            res;
    int                  base;
    west = pin_q[LANE_W-1:0];
    comb = '0;
    taps = '0;
    for (int k = 0; k < NUM_TILES; k++) begin
      // Candidates 0..3 from the west and 4..7 from the high pin nibble
      cand = {pin_q[PIN_W-1:LANE_W], west};
      for (int i = 0; i < LUTS_PER_TILE; i++) begin
        base = i * LUT_CFG_W;
        for (int j = 0; j < LUT_INPUTS; j++) begin
          sel = act_tile[k][base + j*SEL_W +: SEL_W];
          idx[j] = cand[sel];
        end
        mask = act_tile[k][base + MASK_POS +: $bits(lut_mask_t)];
        comb[k*LANE_W + i] = mask[idx];
        east[i] = act_tile[k][base + REG_POS] ? lut_q[k*LANE_W + i] : mask[idx];
      end
      taps[k*LANE_W +: LANE_W] = east;
      west = east;
    end
    for (int p = 0; p < PIN_W; p++) begin
      res[p] = taps[act_egr[p*EGRESS_SEL_W +: EGRESS_SEL_W]];
    end
    return res;
  endfunction

  // Cycle model sampling inputs that are stable at the rising edge
  always @(posedge clk) begin
    if (!rst_n) begin
      m_pin_q = '0;
      m_lut_q = '0;
      m_pin_out = '0;
      act_egr = '0;
      pend_egr = '0;
      for (int k = 0; k < NUM_TILES; k++) begin
        act_tile[k] = '0;
        pend_tile[k] = '0;
      end
    end else begin
      if (en) begin
        m_next = ref_pins(m_pin_q, m_lut_q, m_comb);
        m_pin_out = m_next;
        m_lut_q = m_comb;
        m_pin_q = pin_in;
      end
      // Copy follows the data step so this edge still uses the old config
      if (cset) begin
        act_egr = pend_egr;
        for (int k = 0; k < NUM_TILES; k++) begin
          act_tile[k] = pend_tile[k];
        end
      end
    end
  end

  // Compare on the falling edge away from any update
  always @(negedge clk) begin
    if (rst_n) begin
      check_pins("pin_out", m_pin_out, pin_out);
    end
  end

  // Shifts MSB first and optionally checks what falls out
  task automatic shift_stream(input chain_bits_t bits, input bit check_out,
                              input chain_bits_t prev);
    for (int i = CHAIN_LEN - 1; i >= 0; i--) begin
      @(posedge clk);
      #1;
      cen = 1'b1;
      shift_in = bits[i];
      if (check_out) begin
        @(negedge clk);
        check_bit("shift_out", prev[i], shift_out);
      end
    end
    @(posedge clk);
    #1;
    cen = 1'b0;
    shift_in = 1'b0;
  endtask

  task automatic random_chain(output chain_bits_t v);
    for (int i = 0; i < CHAIN_LEN; i++) begin
      v[i] = $urandom % 2;
    end
  endtask

  // Random config with egress in the top bits so it goes in first
  task automatic load_config(input int reg_mode);
    chain_bits_t stream;
    tile_cfg_t   t;
    for (int k = 0; k < NUM_TILES; k++) begin
      for (int b = 0; b < TILE_CFG_W; b++) begin
        t[b] = $urandom % 2;
      end
      for (int i = 0; i < LUTS_PER_TILE; i++) begin
        if (reg_mode == MODE_COMB) begin
          t[i*LUT_CFG_W + REG_POS] = 1'b0;
        end else if (reg_mode == MODE_REG) begin
          t[i*LUT_CFG_W + REG_POS] = 1'b1;
        end
      end
      pend_tile[k] = t;
      stream[k*TILE_CFG_W +: TILE_CFG_W] = t;
    end
    pend_egr = $urandom;
    stream[CHAIN_LEN-1 -: EGRESS_CFG_W] = pend_egr;
    shift_stream(stream, 1'b0, '0);
  endtask

  task automatic apply_cset();
    @(posedge clk);
    #1;
    cset = 1'b1;
    @(negedge clk);
    check_bit("cset_out", 1'b1, cset_out);
    @(posedge clk);
    #1;
    cset = 1'b0;
  endtask

  task automatic drive_pins(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      pin_in = pin_bus_t'($urandom);
    end
    // Drain the deepest pipeline into the compare
    repeat (NUM_TILES + 3) @(posedge clk);
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %-12s ok", name);
    end else begin
      $display("test %-12s %0d errors", name, errors - err_before);
    end
  endtask

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int          e0;
    chain_bits_t pat_a;
    chain_bits_t pat_b;
    pin_bus_t    held;
    void'($urandom(SEED));
    clk = 1'b0;
    rst_n = 1'b0;
    en = 1'b0;
    cen = 1'b0;
    cset = 1'b0;
    shift_in = 1'b0;
    pin_in = '0;
    checks = 0;
    errors = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    en = 1'b1;

    e0 = errors;
    @(negedge clk);
    check_pins("pin_out", '0, pin_out);
    check_bit("shift_out", 1'b0, shift_out);
    check_bit("cset_out", 1'b0, cset_out);
    end_test("reset", e0);

    // Full chain length of delay on the serial path
    e0 = errors;
    random_chain(pat_a);
    random_chain(pat_b);
    shift_stream(pat_a, 1'b0, '0);
    shift_stream(pat_b, 1'b1, pat_a);
    end_test("passthrough", e0);

    e0 = errors;
    load_config(MODE_COMB);
    apply_cset();
    drive_pins(200);
    end_test("comb", e0);

    e0 = errors;
    load_config(MODE_REG);
    apply_cset();
    drive_pins(100);
    end_test("registered", e0);

    // Second load sits in the shadow until cset
    e0 = errors;
    load_config(MODE_MIX);
    apply_cset();
    drive_pins(40);
    load_config(MODE_MIX);
    drive_pins(40);
    apply_cset();
    drive_pins(40);
    end_test("shadow", e0);

    e0 = errors;
    @(posedge clk);
    #1;
    en = 1'b0;
    @(negedge clk);
    // Model value from the last enabled edge
    held = m_pin_out;
    repeat (30) begin
      @(posedge clk);
      #1;
      pin_in = pin_bus_t'($urandom);
      @(negedge clk);
      check_pins("pin_out", held, pin_out);
    end
    @(posedge clk);
    #1;
    en = 1'b1;
    drive_pins(30);
    end_test("en_hold", e0);

    errors = errors + dut.u_checker.fail_count;
    $display("checks %0d errors %0d assertion failures %0d",
             checks, errors, dut.u_checker.fail_count);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/cfg_chain_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One link of the serial configuration chain
interface cfg_chain_if;

  // Shift enable for the shadow registers
  logic cen;
  // Shadow to active copy strobe
  logic cset;
  // Global data register enable
  logic en;
  // Serial config bit
  logic shift;

  // Upstream stage side
  modport src (output cen, output cset, output en, output shift);

  // Downstream stage side
  modport dst (input cen, input cset, input en, input shift);

endinterface

`default_nettype wire

// ==== hw/fabric_cfg_pkg.sv ====
`default_nettype none

package fabric_cfg_pkg;

  // Row size
  localparam int NUM_TILES = 4;

  // LUT geometry
  localparam int LUT_INPUTS = 4;
  localparam int LUTS_PER_TILE = 4;

  // Eight candidates per LUT input
  localparam int SEL_W = 3;
  // Candidate index: 0..3 west lane, 4..7 broadcast lane
  typedef logic [SEL_W-1:0] lut_sel_t;

  // Truth table, input 0 is the index LSB
  localparam int MASK_W = 1 << LUT_INPUTS;
  typedef logic [MASK_W-1:0] lut_mask_t;

  // Field layout inside one LUT config word
  // Selects at the bottom, input 0 lowest
  localparam int LUT_MASK_LSB = LUT_INPUTS * SEL_W;
  // Output register bit on top
  localparam int LUT_REG_BIT = LUT_MASK_LSB + MASK_W;
  localparam int LUT_CFG_W = LUT_REG_BIT + 1;

  // Whole tile, LUT 0 lowest
  localparam int TILE_CFG_W = LUTS_PER_TILE * LUT_CFG_W;
  typedef logic [TILE_CFG_W-1:0] tile_cfg_t;

  // Egress stage, one tap select per output pin, pin 0 lowest
  localparam int EGRESS_SEL_W = 4;
  localparam int EGRESS_CFG_W = 32;
  typedef logic [EGRESS_CFG_W-1:0] egress_cfg_t;

  // Full chain from shift_in to shift_out
  localparam int CHAIN_LEN = NUM_TILES * TILE_CFG_W + EGRESS_CFG_W;

endpackage

`default_nettype wire

// ==== hw/fabric_io_pkg.sv ====
`default_nettype none

package fabric_io_pkg;

  // External pins, split into separate in and out buses
  localparam int PIN_W = 8;
  typedef logic [PIN_W-1:0] pin_bus_t;

  // Lane between neighbouring tiles
  // Also the width of the broadcast lane
  localparam int LANE_W = 4;
  typedef logic [LANE_W-1:0] lane_t;

  // Every tile's east lane side by side
  // Tile 0 in the lowest bits
  localparam int TAP_W = 16;
  typedef logic [TAP_W-1:0] tap_bus_t;

endpackage

`default_nettype wire

// ==== hw/fabric_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_top
  import fabric_cfg_pkg::*;
  import fabric_io_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en,
  input  logic     cen,
  input  logic     cset,
  input  logic     shift_in,
  input  pin_bus_t pin_in,
  output pin_bus_t pin_out,
  output logic     shift_out,
  output logic     cset_out
);

  // Chain links, link k feeds tile k, the last one feeds egress
  cfg_chain_if chain [NUM_TILES+1] ();

  // Lane k is the west input of tile k
  lane_t lane [NUM_TILES+1];
  lane_t bcast_lane;

  // East lanes collected for the output mux
  tap_bus_t taps;

  // Head of the chain from the pins
  assign chain[0].cen   = cen;
  assign chain[0].cset  = cset;
  assign chain[0].en    = en;
  assign chain[0].shift = shift_in;

  pin_ingress u_ingress (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .pin_in     (pin_in),
    .west_lane  (lane[0]),
    .bcast_lane (bcast_lane)
  );

  // One row of tiles, west to east
  for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
    logic_tile u_tile (
      .clk        (clk),
      .rst_n      (rst_n),
      .chain_in   (chain[k]),
      .chain_out  (chain[k+1]),
      .west_lane  (lane[k]),
      .bcast_lane (bcast_lane),
      .east_lane  (lane[k+1])
    );

    // Tile k owns taps 4k..4k+3
    assign taps[k*LANE_W +: LANE_W] = lane[k+1];
  end

  pin_egress u_egress (
    .clk       (clk),
    .rst_n     (rst_n),
    .chain_in  (chain[NUM_TILES]),
    .taps      (taps),
    .pin_out   (pin_out),
    .shift_out (shift_out),
    .cset_out  (cset_out)
  );

endmodule

`default_nettype wire

// ==== hw/logic_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module logic_tile
  import fabric_cfg_pkg::*;
  import fabric_io_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  cfg_chain_if.dst chain_in,
  cfg_chain_if.src chain_out,
  input  lane_t    west_lane,
  input  lane_t    bcast_lane,
  output lane_t    east_lane
);

  // Config being shifted in
  tile_cfg_t cfg_shadow;
  // Config driving the LUTs
  tile_cfg_t cfg_active;

  // Eight LUT input candidates
  logic [2*LANE_W-1:0] cand;

  // Per LUT results
  logic [LUTS_PER_TILE-1:0] lut_comb;
  logic [LUTS_PER_TILE-1:0] lut_q;
  logic [LUTS_PER_TILE-1:0] lut_reg_en;

  // Shift stage
  // cset copies the pre-shift shadow when both strobes are high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_shadow <= '0;
      cfg_active <= '0;
    end else begin
      if (chain_in.cen) begin
        cfg_shadow <= {cfg_shadow[TILE_CFG_W-2:0], chain_in.shift};
      end
      if (chain_in.cset) begin
        cfg_active <= cfg_shadow;
      end
    end
  end

  // Strobes pass straight through to the next stage
  assign chain_out.cen  = chain_in.cen;
  assign chain_out.cset = chain_in.cset;
  assign chain_out.en   = chain_in.en;
  // Oldest shadow bit leaves the tile
  assign chain_out.shift = cfg_shadow[TILE_CFG_W-1];

  // West lane in 0..3, broadcast in 4..7
  assign cand = {bcast_lane, west_lane};

  for (genvar i = 0; i < LUTS_PER_TILE; i++) begin : g_lut
    // Start of this LUT's field in the tile word
    localparam int lut_base = i * LUT_CFG_W;

    lut_sel_t              sel [LUT_INPUTS];
    lut_mask_t             mask;
    logic [LUT_INPUTS-1:0] idx;

    for (genvar j = 0; j < LUT_INPUTS; j++) begin : g_in
      assign sel[j] = cfg_active[lut_base + j*SEL_W +: SEL_W];
      // Input j lands on index bit j
      assign idx[j] = cand[sel[j]];
    end

    assign mask = cfg_active[lut_base + LUT_MASK_LSB +: MASK_W];

    // Truth table lookup
    assign lut_comb[i] = mask[idx];

    // Register bit sits above the mask
    assign lut_reg_en[i] = cfg_active[lut_base + LUT_REG_BIT];
  end

  // Optional output registers, all gated by en
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lut_q <= '0;
    end else if (chain_in.en) begin
      lut_q <= lut_comb;
    end
  end

  // LUT i drives east lane bit i
  // Per-bit choice between the flop and the raw lookup
  assign east_lane = (lut_reg_en & lut_q) | (~lut_reg_en & lut_comb);

endmodule

`default_nettype wire

// ==== hw/pin_egress.sv ====
`timescale 1ns/1ps
`default_nettype none

module pin_egress
  import fabric_cfg_pkg::*;
  import fabric_io_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  cfg_chain_if.dst chain_in,
  input  tap_bus_t taps,
  output pin_bus_t pin_out,
  output logic     shift_out,
  output logic     cset_out
);

  // Last stage of the chain
  egress_cfg_t cfg_shadow;
  egress_cfg_t cfg_active;

  // Selected tap per output pin, before the register
  pin_bus_t pin_d;

  // Same shift and copy rules as the tiles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_shadow <= '0;
      cfg_active <= '0;
    end else begin
      if (chain_in.cen) begin
        cfg_shadow <= {cfg_shadow[EGRESS_CFG_W-2:0], chain_in.shift};
      end
      if (chain_in.cset) begin
        cfg_active <= cfg_shadow;
      end
    end
  end

  // Output mux, one 16:1 per pin
  for (genvar p = 0; p < PIN_W; p++) begin : g_pin
    logic [EGRESS_SEL_W-1:0] tap_sel;

    assign tap_sel  = cfg_active[p*EGRESS_SEL_W +: EGRESS_SEL_W];
    assign pin_d[p] = taps[tap_sel];
  end

  // Pin register, frozen while en is low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pin_out <= '0;
    end else if (chain_in.en) begin
      pin_out <= pin_d;
    end
  end

  // Chain tail back to the pins
  assign shift_out = cfg_shadow[EGRESS_CFG_W-1];
  // cset echoed so the host can see the strobe traversed the row
  assign cset_out  = chain_in.cset;

endmodule

`default_nettype wire

// ==== hw/pin_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module pin_ingress
  import fabric_io_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en,
  input  pin_bus_t pin_in,
  output lane_t    west_lane,
  output lane_t    bcast_lane
);

  // Registered copy of the input pins
  pin_bus_t pin_q;

  // Capture on every enabled edge
  // Holds while en is low, so the whole row freezes together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pin_q <= '0;
    end else if (en) begin
      pin_q <= pin_in;
    end
  end

  // Low nibble enters tile 0 from the west
  assign west_lane = pin_q[LANE_W-1:0];

  // High nibble goes to every tile at once
  assign bcast_lane = pin_q[PIN_W-1:LANE_W];

endmodule

`default_nettype wire

// ==== tiny_fabric.f ====
hw/fabric_cfg_pkg.sv
hw/fabric_io_pkg.sv
hw/cfg_chain_if.sv
hw/pin_ingress.sv
hw/logic_tile.sv
hw/pin_egress.sv
hw/fabric_top.sv
bench/fabric_checker.sv
bench/fabric_tb.sv
